/* source/isa_pkg.sv */
package isa_pkg;

    // ************************************************************************
    // instruction word, decoded as R, I or J format
    // ************************************************************************
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instr_t;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_jal   = 6'h03;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lb    = 6'h20;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_lbu   = 6'h24;
    localparam logic [5:0] op_sb    = 6'h28;
    localparam logic [5:0] op_sw    = 6'h2b;

    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_add     = 6'h20;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_sub     = 6'h22;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;

    localparam logic [4:0] link_reg = 5'd31; // return address for jal.

endpackage

/* source/core_pkg.sv */
package core_pkg;

    // ************************************************************************
    // alu operation codes
    // ************************************************************************
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_or  = 4'd3;
    localparam logic [3:0] alu_nor = 4'd4;
    localparam logic [3:0] alu_slt = 4'd5; // signed compare.
    localparam logic [3:0] alu_sll = 4'd6;
    localparam logic [3:0] alu_srl = 4'd7;
    localparam logic [3:0] alu_lui = 4'd8;

    // ************************************************************************
    // data memory organisation
    // ************************************************************************
    // lane 0 holds the most significant byte of a word.
    localparam int mem_lanes = 4;

endpackage

/* source/core_if.sv */
`timescale 1ns/10ps

// decoded control lines from control_unit to data_path.
interface ctrl_if;
    logic       reg_dest;   // write rd instead of rt.
    logic       link;       // write register 31.
    logic       alu_src;    // immediate as second operand.
    logic       shift_sel;  // shamt as second operand.
    logic [3:0] alu_op;
    logic       mem_to_reg;
    logic       pc_to_reg;
    logic       reg_write;
    logic       branch;
    logic       branch_ne;
    logic       jump;
    logic       jump_reg;
    logic       mem_write;
    logic       mem_size;   // 1 is word, 0 is byte.
    logic       mem_signed;

    modport source (output reg_dest, link, alu_src, shift_sel, alu_op, mem_to_reg,
                    pc_to_reg, reg_write, branch, branch_ne, jump, jump_reg,
                    mem_write, mem_size, mem_signed);
    modport sink   (input reg_dest, link, alu_src, shift_sel, alu_op, mem_to_reg,
                    pc_to_reg, reg_write, branch, branch_ne, jump, jump_reg,
                    mem_write, mem_size, mem_signed);
endinterface

// data memory access, completes within the cycle.
interface dmem_if #(parameter int xlen = 32);
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            write;
    logic            size;        // 1 is word, 0 is byte.
    logic            signed_load;
    logic [xlen-1:0] rdata;

    modport master (output addr, wdata, write, size, signed_load, input rdata);
    modport slave  (input addr, wdata, write, size, signed_load, output rdata);
endinterface

/* source/control_unit.sv */
`timescale 1ns/10ps

module control_unit import isa_pkg::*, core_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  instr_t inst,
    ctrl_if.source ctrl,
    output logic   halted
);

    logic reg_write_dec;
    logic mem_write_dec;
    logic syscall;

    always_comb begin
        ctrl.reg_dest   = 1'b0;
        ctrl.link       = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.shift_sel  = 1'b0;
        ctrl.alu_op     = alu_add;
        ctrl.mem_to_reg = 1'b0;
        ctrl.pc_to_reg  = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.branch_ne  = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.jump_reg   = 1'b0;
        ctrl.mem_size   = 1'b1;
        ctrl.mem_signed = 1'b0;
        reg_write_dec   = 1'b0;
        mem_write_dec   = 1'b0;
        syscall         = 1'b0;
        case (inst.r.opcode)
            op_rtype: begin
                ctrl.reg_dest = 1'b1;
                reg_write_dec = 1'b1;
                case (inst.r.funct)
                    fn_add, fn_addu: ctrl.alu_op = alu_add;
                    fn_sub:          ctrl.alu_op = alu_sub;
                    fn_and:          ctrl.alu_op = alu_and;
                    fn_or:           ctrl.alu_op = alu_or;
                    fn_nor:          ctrl.alu_op = alu_nor;
                    fn_slt:          ctrl.alu_op = alu_slt;
                    fn_sll: begin
                        ctrl.alu_op    = alu_sll;
                        ctrl.shift_sel = 1'b1;
                    end
                    fn_srl: begin
                        ctrl.alu_op    = alu_srl;
                        ctrl.shift_sel = 1'b1;
                    end
                    fn_jr: begin
                        ctrl.jump_reg = 1'b1;
                        reg_write_dec = 1'b0;
                    end
                    fn_syscall: begin
                        syscall       = 1'b1;
                        reg_write_dec = 1'b0;
                    end
                    default: reg_write_dec = 1'b0; // unknown funct is a no-op.
                endcase
            end
            op_addi, op_addiu: {ctrl.alu_src, reg_write_dec} = 2'b11;
            op_andi: {ctrl.alu_src, reg_write_dec, ctrl.alu_op} = {2'b11, alu_and};
            op_ori:  {ctrl.alu_src, reg_write_dec, ctrl.alu_op} = {2'b11, alu_or};
            op_slti: {ctrl.alu_src, reg_write_dec, ctrl.alu_op} = {2'b11, alu_slt};
            op_lui:  {ctrl.alu_src, reg_write_dec, ctrl.alu_op} = {2'b11, alu_lui};
            op_lw:   {ctrl.alu_src, reg_write_dec, ctrl.mem_to_reg} = 3'b111;
            op_lb:   {ctrl.alu_src, reg_write_dec, ctrl.mem_to_reg, ctrl.mem_size,
                      ctrl.mem_signed} = 5'b11101;
            op_lbu:  {ctrl.alu_src, reg_write_dec, ctrl.mem_to_reg, ctrl.mem_size} = 4'b1110;
            op_sw:   {ctrl.alu_src, mem_write_dec} = 2'b11;
            op_sb:   {ctrl.alu_src, mem_write_dec, ctrl.mem_size} = 3'b110;
            op_beq:  {ctrl.branch, ctrl.alu_op} = {1'b1, alu_sub};
            op_bne:  {ctrl.branch, ctrl.branch_ne, ctrl.alu_op} = {2'b11, alu_sub};
            op_j:    ctrl.jump = 1'b1;
            op_jal:  {ctrl.jump, ctrl.link, ctrl.pc_to_reg, reg_write_dec} = 4'b1111;
            default: ;
        endcase
        // no state may change while in reset or after a halt.
        ctrl.reg_write = reg_write_dec & ~halted & ~reset;
        ctrl.mem_write = mem_write_dec & ~halted & ~reset;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (syscall) begin
            halted <= 1'b1; // held until reset.
        end
    end

endmodule

/* source/alu.sv */
`timescale 1ns/10ps

module alu import core_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [3:0]      op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic less;

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_nor: result = ~(a | b);
            alu_slt: result = {{(xlen-1){1'b0}}, less};
            alu_sll: result = a << b[4:0];
            alu_srl: result = a >> b[4:0];
            alu_lui: result = {b[xlen/2-1:0], {(xlen/2){1'b0}}};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // used by beq and bne.

endmodule

/* source/regfile.sv */
`timescale 1ns/10ps

module regfile #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [4:0]      rs_num,
    input  logic [4:0]      rt_num,
    input  logic [4:0]      rd_num,
    input  logic [xlen-1:0] rd_data,
    input  logic            rd_we,
    output logic [xlen-1:0] rs_data,
    output logic [xlen-1:0] rt_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (rd_we && (rd_num != 5'd0)) begin
            regs[rd_num] <= rd_data;
        end
    end

    assign rs_data = (rs_num == 5'd0) ? '0 : regs[rs_num];
    assign rt_data = (rt_num == 5'd0) ? '0 : regs[rt_num];

endmodule

/* source/data_path.sv */
`timescale 1ns/10ps

module data_path import isa_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            reset,
    input  instr_t          inst,
    ctrl_if.sink            ctrl,
    input  logic            halted,
    dmem_if.master          dmem,
    output logic [xlen-1:0] inst_addr
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_branch;
    logic [xlen-1:0] pc_jump;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] rs_data;
    logic [xlen-1:0] rt_data;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] shamt_ext;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;
    logic [4:0]      wb_num;
    logic            zero_ext;
    logic            alu_zero;
    logic            branch_taken;

    // ************************************************************************
    // operands
    // ************************************************************************
    assign zero_ext  = (inst.i.opcode == op_andi) || (inst.i.opcode == op_ori) ||
                       (inst.i.opcode == op_lui);
    assign imm_ext   = zero_ext ? {{(xlen-16){1'b0}}, inst.i.imm16}
                                : {{(xlen-16){inst.i.imm16[15]}}, inst.i.imm16};
    assign shamt_ext = {{(xlen-5){1'b0}}, inst.r.shamt};

    assign alu_a = ctrl.shift_sel ? rt_data : rs_data; // shifts act on rt.
    assign alu_b = ctrl.shift_sel ? shamt_ext : (ctrl.alu_src ? imm_ext : rt_data);

    regfile #(.xlen(xlen)) u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_num  (inst.r.rs),
        .rt_num  (inst.r.rt),
        .rd_num  (wb_num),
        .rd_data (wb_data),
        .rd_we   (ctrl.reg_write),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu #(.xlen(xlen)) u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // ************************************************************************
    // write back and memory side
    // ************************************************************************
    assign wb_num  = ctrl.link ? link_reg : (ctrl.reg_dest ? inst.r.rd : inst.r.rt);
    assign wb_data = ctrl.pc_to_reg  ? pc_plus4 :
                     ctrl.mem_to_reg ? dmem.rdata : alu_result;

    assign dmem.addr        = alu_result;
    assign dmem.wdata       = rt_data;
    assign dmem.write       = ctrl.mem_write;
    assign dmem.size        = ctrl.mem_size;
    assign dmem.signed_load = ctrl.mem_signed;

    // ************************************************************************
    // next pc
    // ************************************************************************
    assign pc_plus4     = pc + xlen'(4);
    assign pc_branch    = pc_plus4 + (imm_ext << 2);
    assign pc_jump      = {pc_plus4[xlen-1:28], inst.j.target26, 2'b00};
    assign branch_taken = ctrl.branch & (ctrl.branch_ne ? ~alu_zero : alu_zero);
    assign pc_next      = ctrl.jump_reg ? rs_data :
                          ctrl.jump     ? pc_jump :
                          branch_taken  ? pc_branch : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!halted) begin
            pc <= pc_next;
        end
    end

    assign inst_addr = pc;

endmodule

/* source/store_lane_steer.sv */
`timescale 1ns/10ps

module store_lane_steer import core_pkg::*; (
    dmem_if.slave                  dmem,
    output logic [mem_lanes-1:0]   lane_we,
    output logic [7:0]             lane_wdata [mem_lanes],
    output logic [29:0]            word_index
);

    always_comb begin
        for (int i = 0; i < mem_lanes; i++) begin
            if (dmem.size) begin
                // word store, lane 0 takes the top byte.
                lane_wdata[i] = dmem.wdata[8*(mem_lanes-1-i) +: 8];
                lane_we[i]    = dmem.write;
            end else begin
                lane_wdata[i] = dmem.wdata[7:0];
                lane_we[i]    = dmem.write && (dmem.addr[1:0] == 2'(i));
            end
        end
    end

    assign word_index = dmem.addr[31:2]; // byte address to word.

endmodule

/* source/byte_bank.sv */
`timescale 1ns/10ps

module byte_bank #(
    parameter int dmem_depth = 256
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(dmem_depth)-1:0] index,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata
);

    logic [7:0] mem [dmem_depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index]; // read within the same cycle.

endmodule

/* source/load_lane_merge.sv */
`timescale 1ns/10ps

module load_lane_merge import core_pkg::*; (
    input  logic [7:0] lane_rdata [mem_lanes],
    input  logic [1:0] byte_sel,
    dmem_if.slave      dmem
);

    logic [8*mem_lanes-1:0] word;
    logic [7:0]             sel_byte;
    logic                   fill;

    always_comb begin
        for (int i = 0; i < mem_lanes; i++) begin
            word[8*(mem_lanes-1-i) +: 8] = lane_rdata[i]; // big-endian.
        end
    end

    assign sel_byte = lane_rdata[byte_sel];
    assign fill     = dmem.signed_load & sel_byte[7];

    always_comb begin
        if (dmem.size) begin
            dmem.rdata = word;
        end else begin
            dmem.rdata = {{(8*mem_lanes-8){fill}}, sel_byte}; // lb or lbu.
        end
    end

endmodule

/* source/mips_core.sv */
`timescale 1ns/10ps

module mips_core import core_pkg::*; #(
    parameter int xlen       = 32,
    parameter int dmem_depth = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] inst,
    output logic [xlen-1:0] inst_addr,
    output logic            halted,
    output logic            mem_write,
    output logic [xlen-1:0] mem_addr,
    output logic [xlen-1:0] mem_wdata
);

    localparam int bank_aw = $clog2(dmem_depth);

    logic [mem_lanes-1:0] lane_we;
    logic [7:0]           lane_wdata [mem_lanes];
    logic [7:0]           lane_rdata [mem_lanes];
    logic [29:0]          word_index;

    ctrl_if               ctrl ();
    dmem_if #(.xlen(xlen)) dmem ();

    control_unit u_control_unit (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .ctrl   (ctrl.source),
        .halted (halted)
    );

    data_path #(.xlen(xlen)) u_data_path (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .ctrl      (ctrl.sink),
        .halted    (halted),
        .dmem      (dmem.master),
        .inst_addr (inst_addr)
    );

    // ************************************************************************
    // data memory, one bank per byte lane
    // ************************************************************************
    store_lane_steer u_store_lane_steer (
        .dmem       (dmem.slave),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .word_index (word_index)
    );

    for (genvar g = 0; g < mem_lanes; g++) begin : g_bank
        byte_bank #(.dmem_depth(dmem_depth)) u_byte_bank (
            .clk   (clk),
            .we    (lane_we[g]),
            .index (word_index[bank_aw-1:0]),
            .wdata (lane_wdata[g]),
            .rdata (lane_rdata[g])
        );
    end

    load_lane_merge u_load_lane_merge (
        .lane_rdata (lane_rdata),
        .byte_sel   (dmem.addr[1:0]),
        .dmem       (dmem.slave)
    );

    assign mem_write = dmem.write;
    assign mem_addr  = dmem.addr;
    assign mem_wdata = dmem.wdata;

endmodule

/* dv/mips_core_tb.sv */
`timescale 1ns/10ps

module mips_core_tb import isa_pkg::*; ();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int halt_limit   = 200;  // longest program with its loops, plus margin.
    localparam int hold_cycles  = 10;
    // six programs, each 8 reset cycles and at most 60 instructions and 10 hold cycles,
    // with loops and margin on top.
    localparam int cycle_limit  = 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic        halted;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;

    logic [31:0] prog [256];
    int          prog_len;
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          seed   = 44;
    int          cycles = 0;
    int          errors;
    int          passed = 0;
    int          failed = 0;

    mips_core #(.xlen(32), .dmem_depth(256)) u_dut (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .inst_addr (inst_addr),
        .halted    (halted),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    assign inst = prog[inst_addr[9:2]]; // program memory answers within the cycle.

    initial begin
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // store log and run limit.
    always @(posedge clk) begin
        cycles++;
        if (mem_write) begin
            log_addr.push_back(mem_addr);
            log_data.push_back(mem_wdata);
        end
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a test never finished", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ************************************************************************
    // instruction encoding and program building
    // ************************************************************************
    function automatic instr_t rtype(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                     logic [4:0] rd, logic [4:0] sh);
        instr_t w;
        w.r = {op_rtype, rs, rt, rd, sh, fn};
        return w;
    endfunction

    function automatic instr_t itype(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                     logic [15:0] imm);
        instr_t w;
        w.i = {op, rs, rt, imm};
        return w;
    endfunction

    function automatic instr_t jtype(logic [5:0] op, logic [25:0] target);
        instr_t w;
        w.j = {op, target};
        return w;
    endfunction

    function automatic logic [31:0] sext8(logic [7:0] b);
        return {{24{b[7]}}, b};
    endfunction

    function automatic logic [31:0] sext16(logic [15:0] h);
        return {{16{h[15]}}, h};
    endfunction

    task automatic emit(instr_t word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            prog[i] = {op_rtype, 20'(i), fn_syscall}; // syscall, code field holds the index.
        end
        prog_len = 0;
    endtask

    task automatic set_reg(logic [4:0] r, logic [31:0] value);
        emit(itype(op_lui, 0, r, value[31:16]));
        emit(itype(op_ori, r, r, value[15:0]));
    endtask

    // offset counts words from the instruction after the branch.
    task automatic branch_to(logic [5:0] op, logic [4:0] rs, logic [4:0] rt, int target);
        int offset;
        offset = target - (prog_len + 1);
        emit(itype(op, rs, rt, offset[15:0]));
    endtask

    task automatic marker(logic [15:0] value, logic [15:0] offset);
        emit(itype(op_ori, 0, 4, value));
        emit(itype(op_sw, 0, 4, offset));
    endtask

    task automatic expect_store(logic [31:0] addr, logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic store_result(logic [15:0] offset, logic [31:0] value);
        emit(itype(op_sw, 0, 3, offset)); // results are built in r3.
        expect_store({16'h0, offset}, value);
    endtask

    // ************************************************************************
    // running and checking
    // ************************************************************************
    task automatic begin_program();
        @(negedge clk);
        reset = 1'b1;
        clear_program();
        exp_addr.delete();
        exp_data.delete();
        errors = 0;
    endtask

    task automatic run_program(string name);
        int waited;
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clk);
            if (halted !== 1'b0 || mem_write !== 1'b0 || inst_addr !== 32'h0) begin
                $display("Fail %s: expected halted 0, mem_write 0, pc %h in reset, actual %b, %b, %h",
                         name, 32'h0, halted, mem_write, inst_addr);
                errors++;
            end
        end
        log_addr.delete();
        log_data.delete();
        reset  = 1'b0;
        waited = 0;
        while (halted !== 1'b1 && waited < halt_limit) begin
            @(negedge clk);
            waited++;
        end
        if (halted !== 1'b1) begin
            $display("%s: core did not halt within %0d cycles", name, halt_limit);
            errors++;
        end
    endtask

    task automatic check_stores(string name);
        if (log_addr.size() != exp_addr.size()) begin
            $display("Fail %s: expected %0d stores, actual %0d", name, exp_addr.size(),
                     log_addr.size());
            errors++;
        end else begin
            for (int i = 0; i < exp_addr.size(); i++) begin
                if (errors == 0 && (log_addr[i] !== exp_addr[i] || log_data[i] !== exp_data[i]))
                begin
                    $display("Fail %s: store %0d expected %h at %h, actual %h at %h", name, i,
                             exp_data[i], exp_addr[i], log_data[i], log_addr[i]);
                    errors++;
                end
            end
        end
        if (errors == 0) begin
            $display("pass %s: expected %0d stores, actual %0d", name, exp_addr.size(),
                     log_addr.size());
            passed++;
        end else begin
            $display("Fail %s: expected 0 errors, actual %0d", name, errors);
            failed++;
        end
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic arith_logic();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        logic [15:0] imm;
        logic [4:0]  sh;
        a   = $random(seed);
        b   = $random(seed);
        rnd = $random(seed);
        imm = rnd[15:0];
        sh  = rnd[20:16];
        begin_program();
        set_reg(1, a);
        set_reg(2, b);
        emit(rtype(fn_add, 1, 2, 3, 0));
        store_result(0, a + b);
        emit(rtype(fn_sub, 1, 2, 3, 0));
        store_result(4, a - b);
        emit(rtype(fn_and, 1, 2, 3, 0));
        store_result(8, a & b);
        emit(rtype(fn_or, 1, 2, 3, 0));
        store_result(12, a | b);
        emit(rtype(fn_nor, 1, 2, 3, 0));
        store_result(16, ~(a | b));
        emit(rtype(fn_slt, 1, 2, 3, 0));
        store_result(20, {31'h0, $signed(a) < $signed(b)});
        emit(rtype(fn_sll, 0, 1, 3, sh));
        store_result(24, a << sh);
        emit(rtype(fn_srl, 0, 1, 3, sh));
        store_result(28, a >> sh);
        emit(itype(op_addi, 1, 3, imm));
        store_result(32, a + sext16(imm));
        emit(itype(op_andi, 1, 3, imm));
        store_result(36, a & {16'h0, imm});
        emit(itype(op_slti, 1, 3, imm));
        store_result(40, {31'h0, $signed(a) < $signed(sext16(imm))});
        emit(rtype(fn_syscall, 0, 0, 0, 0));
        run_program("arith");
        check_stores("arith");
    endtask

    task automatic memory_round_trip();
        logic [31:0] w;
        logic [31:0] rnd;
        logic [7:0]  b1;
        logic [7:0]  b2;
        w   = $random(seed);
        rnd = $random(seed);
        b1  = rnd[7:0] | 8'h80;   // negative byte.
        b2  = rnd[15:8] & 8'h7f;  // positive byte.
        begin_program();
        set_reg(1, w);
        emit(itype(op_sw, 0, 1, 16'd64));
        expect_store(64, w);
        emit(itype(op_ori, 0, 2, {8'h0, b1}));
        emit(itype(op_sb, 0, 2, 16'd65));
        expect_store(65, {24'h0, b1});
        emit(itype(op_ori, 0, 2, {8'h0, b2}));
        emit(itype(op_sb, 0, 2, 16'd66));
        expect_store(66, {24'h0, b2});
        emit(itype(op_lw, 0, 3, 16'd64));
        store_result(0, {w[31:24], b1, b2, w[7:0]}); // byte 64 is the top byte.
        emit(itype(op_lb, 0, 3, 16'd65));
        store_result(4, sext8(b1));
        emit(itype(op_lbu, 0, 3, 16'd65));
        store_result(8, {24'h0, b1});
        emit(itype(op_lb, 0, 3, 16'd66));
        store_result(12, sext8(b2));
        emit(itype(op_lbu, 0, 3, 16'd64));
        store_result(16, {24'h0, w[31:24]});
        emit(itype(op_lb, 0, 3, 16'd67));
        store_result(20, sext8(w[7:0]));
        emit(rtype(fn_syscall, 0, 0, 0, 0));
        run_program("memory");
        check_stores("memory");
    endtask

    task automatic branch_paths();
        begin_program();
        emit(itype(op_ori, 0, 1, 16'd5));
        emit(itype(op_ori, 0, 2, 16'd5));
        emit(itype(op_ori, 0, 3, 16'd7));
        branch_to(op_beq, 1, 2, 6);          // taken forward.
        marker(16'hbad1, 0);
        branch_to(op_beq, 1, 3, 9);          // not taken.
        marker(16'h00a1, 0);
        branch_to(op_bne, 1, 3, 12);         // taken forward.
        marker(16'hbad2, 4);
        branch_to(op_bne, 1, 2, 15);         // not taken.
        marker(16'h00a2, 4);
        emit(itype(op_ori, 0, 5, 16'd3));
        emit(itype(op_ori, 0, 7, 16'd1));
        emit(itype(op_addi, 5, 5, 16'hffff)); // index 17, count down.
        emit(itype(op_sw, 0, 5, 16'd8));
        branch_to(op_bne, 5, 0, 17);         // taken backward twice.
        emit(itype(op_addi, 6, 6, 16'd1));   // index 20.
        emit(itype(op_sw, 0, 6, 16'd12));
        branch_to(op_beq, 6, 7, 20);         // taken backward once.
        emit(rtype(fn_syscall, 0, 0, 0, 0));
        expect_store(0, 32'h0a1);
        expect_store(4, 32'h0a2);
        expect_store(8, 32'd2);
        expect_store(8, 32'd1);
        expect_store(8, 32'd0);
        expect_store(12, 32'd1);
        expect_store(12, 32'd2);
        run_program("branches");
        check_stores("branches");
    endtask

    task automatic jumps_and_link();
        int jal_at;
        begin_program();
        emit(jtype(op_j, 26'd3));
        marker(16'h0bad, 0);
        jal_at = prog_len;
        emit(jtype(op_jal, 26'd7));
        emit(itype(op_sw, 0, 31, 16'd4));     // after the return.
        emit(rtype(fn_syscall, 0, 0, 0, 0));
        emit(rtype(fn_syscall, 0, 0, 0, 0));
        marker(16'h00c1, 0);                 // subroutine at index 7.
        emit(rtype(fn_jr, 31, 0, 0, 0));
        expect_store(0, 32'h0c1);
        expect_store(4, 32'(jal_at * 4 + 4));
        run_program("jumps");
        check_stores("jumps");
    endtask

    task automatic reg_zero_write();
        logic [31:0] v;
        v = $random(seed);
        v = v | 32'h1;
        begin_program();
        set_reg(1, v);
        emit(itype(op_ori, 0, 0, 16'h1234));
        emit(rtype(fn_add, 1, 1, 0, 0));
        emit(itype(op_sw, 0, 0, 16'd0));
        emit(itype(op_sw, 0, 1, 16'd4));
        emit(itype(op_lw, 0, 0, 16'd4));
        emit(itype(op_sw, 0, 0, 16'd8));
        emit(rtype(fn_syscall, 0, 0, 0, 0));
        expect_store(0, 32'h0);
        expect_store(4, v);
        expect_store(8, 32'h0);
        run_program("reg_zero");
        check_stores("reg_zero");
    endtask

    task automatic reset_and_halt();
        logic [31:0] held;
        begin_program();
        emit(itype(op_sw, 0, 0, 16'd16));    // a store at pc 0 must stay quiet in reset.
        emit(itype(op_ori, 0, 1, 16'h0055));
        emit(rtype(fn_syscall, 0, 0, 0, 0));
        emit(itype(op_sw, 0, 1, 16'd20));
        emit(jtype(op_j, 26'd0));
        expect_store(16, 32'h0);
        run_program("reset_halt");
        held = inst_addr;
        for (int i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                $display("Fail reset_halt: expected halted 1, actual %b, %0d cycles after halt",
                         halted, i + 1);
                errors++;
            end
            if (inst_addr !== held) begin
                $display("Fail reset_halt: expected inst_addr %h, actual %h", held, inst_addr);
                errors++;
            end
        end
        check_stores("reset_halt");
    endtask

    initial begin
        reset = 1'b1;
        clear_program();
        arith_logic();
        memory_round_trip();
        branch_paths();
        jumps_and_link();
        reg_zero_write();
        reset_and_halt();
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/isa_pkg.sv
source/core_pkg.sv
source/core_if.sv
source/control_unit.sv
source/alu.sv
source/regfile.sv
source/data_path.sv
source/store_lane_steer.sv
source/byte_bank.sv
source/load_lane_merge.sv
source/mips_core.sv
dv/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mips_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mips_core_tb \
    -f filelist.f -o sim_mips_core

./obj_dir/sim_mips_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    exit 1
fi
